/* list.f */
rtl/exu_pkg.sv
rtl/mux_key_with_default.sv
rtl/gpr.sv
rtl/idu.sv
rtl/exu.sv
rtl/exec_core.sv
testbench/exec_core_tb.sv

/* rtl/exec_core.sv */
`timescale 1ns/1ps

module exec_core #(
  parameter int REG_COUNT = 32
) (
  input  logic             clock,
  input  logic             rst,
  input  logic             inst_valid,
  input  logic [31:0]      inst,
  output exu_pkg::commit_t commit
);

  exu_pkg::dec_op_t         ex_op;
  logic [4:0]               rs1;
  logic [4:0]               rs2;
  logic [exu_pkg::XLEN-1:0] rdata1;
  logic [exu_pkg::XLEN-1:0] rdata2;
  logic [exu_pkg::XLEN-1:0] alu_result;
  logic                     zero;
  logic                     wb_en;

  // Retiring instruction writes back, and the same condition gates the bypass
  assign wb_en = ex_op.valid && !ex_op.illegal && (ex_op.rd != 5'd0);

  idu idu0 (
    .clock      (clock),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rdata1     (rdata1),
    .rdata2     (rdata2),
    .fwd_valid  (wb_en),
    .fwd_rd     (ex_op.rd),
    .fwd_data   (alu_result),
    .ex_op      (ex_op)
  );

  exu exu0 (
    .src1       (ex_op.src1),
    .src2       (ex_op.src2),
    .alu_op     (ex_op.op),
    .alu_result (alu_result),
    .zero       (zero)
  );

  gpr #(
    .REG_COUNT (REG_COUNT)
  ) gpr0 (
    .clock  (clock),
    .rst    (rst),
    .wen    (wb_en),
    .waddr  (ex_op.rd),
    .wdata  (alu_result),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  // Commit lands on the same edge as the register write
  always_ff @(posedge clock) begin
    commit.valid   <= ex_op.valid;
    commit.illegal <= ex_op.illegal;
    commit.rd      <= ex_op.rd;
    commit.result  <= alu_result;
    commit.zero    <= zero;
    if (rst) begin
      commit.valid <= 1'b0;
    end
  end

endmodule

/* rtl/exu.sv */
`timescale 1ns/1ps

module exu (
  input  logic [exu_pkg::XLEN-1:0] src1,
  input  logic [exu_pkg::XLEN-1:0] src2,
  input  exu_pkg::alu_op_e         alu_op,
  output logic [exu_pkg::XLEN-1:0] alu_result,
  output logic                     zero
);

  localparam int XLEN    = exu_pkg::XLEN;
  localparam int NR_OPS  = 11;
  localparam int KEY_LEN = $bits(exu_pkg::alu_op_e);

  logic [XLEN-1:0] res_add;
  logic [XLEN-1:0] res_sub;
  logic [XLEN-1:0] res_and;
  logic [XLEN-1:0] res_xor;
  logic [XLEN-1:0] res_or;
  logic [XLEN-1:0] res_sl;
  logic [XLEN-1:0] res_sr;
  logic [XLEN-1:0] res_ssr;
  logic [XLEN-1:0] res_sles;
  logic [XLEN-1:0] res_ules;
  logic [XLEN:0]   ules_diff;
  logic [4:0]      shamt;

  // Every operation is evaluated in parallel, the key picks one
  assign shamt    = src2[4:0];
  assign res_add  = src1 + src2;
  assign res_sub  = src1 - src2;
  assign res_and  = src1 & src2;
  assign res_xor  = src1 ^ src2;
  assign res_or   = src1 | src2;
  assign res_sl   = src1 << shamt;
  assign res_sr   = src1 >> shamt;
  assign res_ssr  = $signed(src1) >>> shamt;
  assign res_sles = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};

  // Borrow out of a widened subtract gives the unsigned compare
  assign ules_diff = {1'b0, src1} - {1'b0, src2};
  assign res_ules  = {{(XLEN-1){1'b0}}, ules_diff[XLEN]};

  mux_key_with_default #(
    .NR_KEY  (NR_OPS),
    .KEY_LEN (KEY_LEN),
    .data_t  (logic [XLEN-1:0])
  ) result_mux (
    .out         (alu_result),
    .key         (alu_op),
    .default_out ('0),
    .lut ({
      exu_pkg::OP_IMM,  src2,
      exu_pkg::OP_ADD,  res_add,
      exu_pkg::OP_SUB,  res_sub,
      exu_pkg::OP_AND,  res_and,
      exu_pkg::OP_XOR,  res_xor,
      exu_pkg::OP_OR,   res_or,
      exu_pkg::OP_SL,   res_sl,
      exu_pkg::OP_SR,   res_sr,
      exu_pkg::OP_SSR,  res_ssr,
      exu_pkg::OP_SLES, res_sles,
      exu_pkg::OP_ULES, res_ules
    })
  );

  // Zero flag only for add and sub, everything else falls to default
  mux_key_with_default #(
    .NR_KEY  (2),
    .KEY_LEN (KEY_LEN),
    .data_t  (logic)
  ) zero_mux (
    .out         (zero),
    .key         (alu_op),
    .default_out (1'b0),
    .lut ({
      exu_pkg::OP_ADD, (res_add == '0),
      exu_pkg::OP_SUB, (res_sub == '0)
    })
  );

endmodule

/* rtl/exu_pkg.sv */
package exu_pkg;

  // Data width of the integer datapath
  localparam int XLEN = 32;

  // ALU operation codes, zero reserved for an undecoded instruction
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_IMM  = 4'd1,
    OP_ADD  = 4'd2,
    OP_SUB  = 4'd3,
    OP_AND  = 4'd4,
    OP_XOR  = 4'd5,
    OP_OR   = 4'd6,
    OP_SL   = 4'd7,
    OP_SR   = 4'd8,
    OP_SSR  = 4'd9,
    OP_SLES = 4'd10,
    OP_ULES = 4'd11
  } alu_op_e;

  // One decoded instruction with its operands already resolved
  typedef struct packed {
    logic            valid;
    logic            illegal;
    logic [4:0]      rd;
    alu_op_e         op;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
  } dec_op_t;

  // One retired instruction as seen on the commit output
  typedef struct packed {
    logic            valid;
    logic            illegal;
    logic [4:0]      rd;
    logic [XLEN-1:0] result;
    logic            zero;
  } commit_t;

endpackage

/* rtl/gpr.sv */
`timescale 1ns/1ps

module gpr #(
  parameter int  REG_COUNT = 32,
  localparam int ADDR_W    = $clog2(REG_COUNT)
) (
  input  logic                     clock,
  input  logic                     rst,
  input  logic                     wen,
  input  logic [ADDR_W-1:0]        waddr,
  input  logic [exu_pkg::XLEN-1:0] wdata,
  input  logic [ADDR_W-1:0]        raddr1,
  input  logic [ADDR_W-1:0]        raddr2,
  output logic [exu_pkg::XLEN-1:0] rdata1,
  output logic [exu_pkg::XLEN-1:0] rdata2
);

  logic [exu_pkg::XLEN-1:0] regs [REG_COUNT];

  // Architectural state starts cleared
  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is hardwired, so never trust the array slot
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* rtl/idu.sv */
`timescale 1ns/1ps

module idu (
  input  logic                     clock,
  input  logic                     rst,
  input  logic                     inst_valid,
  input  logic [31:0]              inst,
  output logic [4:0]               rs1,
  output logic [4:0]               rs2,
  input  logic [exu_pkg::XLEN-1:0] rdata1,
  input  logic [exu_pkg::XLEN-1:0] rdata2,
  input  logic                     fwd_valid,
  input  logic [4:0]               fwd_rd,
  input  logic [exu_pkg::XLEN-1:0] fwd_data,
  output exu_pkg::dec_op_t         ex_op
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [exu_pkg::XLEN-1:0] reg1;
  logic [exu_pkg::XLEN-1:0] reg2;
  logic [exu_pkg::XLEN-1:0] imm;
  logic                     use_imm;
  logic                     is_lui;
  logic                     illegal;
  exu_pkg::alu_op_e         op;
  exu_pkg::dec_op_t         next_op;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  always_comb begin
    op      = exu_pkg::OP_NONE;
    illegal = 1'b0;
    use_imm = 1'b0;
    is_lui  = 1'b0;
    imm     = {{20{inst[31]}}, inst[31:20]};
    case (opcode)
      OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: op = exu_pkg::OP_ADD;
          10'b0100000_000: op = exu_pkg::OP_SUB;
          10'b0000000_001: op = exu_pkg::OP_SL;
          10'b0000000_010: op = exu_pkg::OP_SLES;
          10'b0000000_011: op = exu_pkg::OP_ULES;
          10'b0000000_100: op = exu_pkg::OP_XOR;
          10'b0000000_101: op = exu_pkg::OP_SR;
          10'b0100000_101: op = exu_pkg::OP_SSR;
          10'b0000000_110: op = exu_pkg::OP_OR;
          10'b0000000_111: op = exu_pkg::OP_AND;
          default:         illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000: op = exu_pkg::OP_ADD;
          3'b010: op = exu_pkg::OP_SLES;
          3'b011: op = exu_pkg::OP_ULES;
          3'b100: op = exu_pkg::OP_XOR;
          3'b110: op = exu_pkg::OP_OR;
          3'b111: op = exu_pkg::OP_AND;
          default: begin
            // Shifts only look at the shamt field
            imm = {27'b0, inst[24:20]};
            if (funct3 == 3'b001 && funct7 == 7'b0000000) begin
              op = exu_pkg::OP_SL;
            end else if (funct3 == 3'b101 && funct7 == 7'b0000000) begin
              op = exu_pkg::OP_SR;
            end else if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
              op = exu_pkg::OP_SSR;
            end else begin
              illegal = 1'b1;
            end
          end
        endcase
      end
      OPC_LUI: begin
        op      = exu_pkg::OP_IMM;
        use_imm = 1'b1;
        is_lui  = 1'b1;
        imm     = {inst[31:12], 12'b0};
      end
      default: illegal = 1'b1;
    endcase
  end

  // Bypass the result still sitting in the execute stage
  assign reg1 = (fwd_valid && fwd_rd == rs1) ? fwd_data : rdata1;
  assign reg2 = (fwd_valid && fwd_rd == rs2) ? fwd_data : rdata2;

  always_comb begin
    next_op.valid   = inst_valid;
    next_op.illegal = illegal;
    next_op.rd      = inst[11:7];
    next_op.op      = op;
    next_op.src1    = is_lui ? '0 : reg1;
    next_op.src2    = use_imm ? imm : reg2;
  end

  always_ff @(posedge clock) begin
    ex_op <= next_op;
    if (rst) begin
      ex_op.valid <= 1'b0;
    end
  end

endmodule

/* rtl/mux_key_with_default.sv */
`timescale 1ns/1ps

module mux_key_with_default #(
  parameter int  NR_KEY  = 2,
  parameter int  KEY_LEN = 1,
  parameter type data_t  = logic [31:0]
) (
  output data_t                                          out,
  input  logic [KEY_LEN-1:0]                             key,
  input  data_t                                          default_out,
  input  logic [NR_KEY*(KEY_LEN+$bits(data_t))-1:0]      lut
);

  localparam int DATA_LEN = $bits(data_t);
  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  // Each pair is {key, value}; the first pair in the concatenation sits at the top
  always_comb begin
    logic [PAIR_LEN-1:0] pair;
    out = default_out;
    for (int i = 0; i < NR_KEY; i++) begin
      pair = lut[PAIR_LEN*i +: PAIR_LEN];
      if (pair[PAIR_LEN-1 -: KEY_LEN] == key) begin
        out = data_t'(pair[DATA_LEN-1:0]);
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
SIM=exec_core_sim

verilator --binary --timing -f list.f --top-module exec_core_tb \
  -Mdir "$OBJ_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

/* testbench/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb;

  localparam logic [31:0] SEED        = 32'h5eec_2936;
  localparam int          NUM_RANDOM  = 200;
  localparam int          DRAIN_LIMIT = 10;

  // One directed row with its hand-computed outcome
  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] result;
    logic        zero;
    logic        illegal;
  } row_t;

  // Expected commit and the cycle it is due
  typedef struct packed {
    logic [31:0]      due;
    exu_pkg::commit_t exp;
  } pending_t;

  logic             clock;
  logic             rst;
  logic             inst_valid;
  logic [31:0]      inst;
  exu_pkg::commit_t commit;

  logic [31:0] model_regs [32];
  row_t        rows [$];
  pending_t    pend [$];
  logic [31:0] cycle_count;
  logic        checking;
  int          checks;
  int          value_errors;
  int          other_errors;

  exec_core #(
    .REG_COUNT (32)
  ) dut0 (
    .clock      (clock),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .commit     (commit)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 32'd1;
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // Reference model following the RV32I rules for the supported subset
  function automatic exu_pkg::commit_t model_commit(input logic [31:0] word);
    logic [6:0]       opcode;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      imm;
    logic [4:0]       sh;
    logic             add_sub;
    exu_pkg::commit_t c;
    opcode    = word[6:0];
    f3        = word[14:12];
    f7        = word[31:25];
    a         = model_regs[word[19:15]];
    b         = model_regs[word[24:20]];
    imm       = {{20{word[31]}}, word[31:20]};
    sh        = word[24:20];
    add_sub   = 1'b0;
    c.valid   = 1'b1;
    c.illegal = 1'b0;
    c.rd      = word[11:7];
    c.result  = 32'd0;
    if (opcode == 7'b0110011) begin
      case ({f7, f3})
        {7'h00, 3'd0}: begin
          c.result = a + b;
          add_sub  = 1'b1;
        end
        {7'h20, 3'd0}: begin
          c.result = a - b;
          add_sub  = 1'b1;
        end
        {7'h00, 3'd1}: c.result = a << b[4:0];
        {7'h00, 3'd2}: c.result = {31'b0, $signed(a) < $signed(b)};
        {7'h00, 3'd3}: c.result = {31'b0, a < b};
        {7'h00, 3'd4}: c.result = a ^ b;
        {7'h00, 3'd5}: c.result = a >> b[4:0];
        {7'h20, 3'd5}: c.result = $signed(a) >>> b[4:0];
        {7'h00, 3'd6}: c.result = a | b;
        {7'h00, 3'd7}: c.result = a & b;
        default:       c.illegal = 1'b1;
      endcase
    end else if (opcode == 7'b0010011) begin
      case (f3)
        3'd0: begin
          c.result = a + imm;
          add_sub  = 1'b1;
        end
        3'd2: c.result = {31'b0, $signed(a) < $signed(imm)};
        3'd3: c.result = {31'b0, a < imm};
        3'd4: c.result = a ^ imm;
        3'd6: c.result = a | imm;
        3'd7: c.result = a & imm;
        3'd1: begin
          if (f7 == 7'h00) c.result = a << sh;
          else c.illegal = 1'b1;
        end
        default: begin
          if (f7 == 7'h00) c.result = a >> sh;
          else if (f7 == 7'h20) c.result = $signed(a) >>> sh;
          else c.illegal = 1'b1;
        end
      endcase
    end else if (opcode == 7'b0110111) begin
      c.result = {word[31:12], 12'b0};
    end else begin
      c.illegal = 1'b1;
    end
    if (c.illegal) c.result = 32'd0;
    c.zero = add_sub && !c.illegal && (c.result == 32'd0);
    return c;
  endfunction

  task automatic model_write(input exu_pkg::commit_t c);
    if (c.valid && !c.illegal && c.rd != 5'd0) begin
      model_regs[c.rd] = c.result;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Random instruction from the legal OP and OP-IMM groups, low registers for dependencies
  function automatic logic [31:0] rand_legal_inst();
    logic [31:0] rnd;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int unsigned pick;
    rnd  = $urandom();
    pick = $urandom() % 10;
    rd   = {2'b00, rnd[2:0]};
    rs1  = {2'b00, rnd[5:3]};
    rs2  = {2'b00, rnd[8:6]};
    if (rnd[31]) begin
      if (pick < 8) begin
        f3 = pick[2:0];
        f7 = 7'h00;
      end else if (pick == 8) begin
        f3 = 3'd0;
        f7 = 7'h20;
      end else begin
        f3 = 3'd5;
        f7 = 7'h20;
      end
      return enc_r(f7, rs2, rs1, f3, rd);
    end
    f3 = rnd[11:9];
    if (f3 == 3'd1) return enc_i({7'h00, rnd[16:12]}, rs1, f3, rd);
    if (f3 == 3'd5) return enc_i({rnd[17] ? 7'h20 : 7'h00, rnd[16:12]}, rs1, f3, rd);
    return enc_i(rnd[23:12], rs1, f3, rd);
  endfunction

  task automatic add_row(input logic [31:0] word, input logic [31:0] result,
                         input logic zero, input logic illegal);
    row_t r;
    r.inst    = word;
    r.result  = result;
    r.zero    = zero;
    r.illegal = illegal;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // x3 and x4 read before any write
    add_row(enc_r(7'h00, 5'd4, 5'd3, 3'd0, 5'd5), 32'h0000_0000, 1'b1, 1'b0);
    add_row(enc_u(20'h80000, 5'd1), 32'h8000_0000, 1'b0, 1'b0);
    add_row(enc_i(12'hfff, 5'd0, 3'd0, 5'd2), 32'hffff_ffff, 1'b0, 1'b0);
    add_row(enc_i(12'h005, 5'd0, 3'd0, 5'd3), 32'h0000_0005, 1'b0, 1'b0);
    add_row(enc_i(12'h7ff, 5'd0, 3'd0, 5'd4), 32'h0000_07ff, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd6), 32'h7fff_ffff, 1'b0, 1'b0);
    // Distance one on both sources
    add_row(enc_r(7'h20, 5'd6, 5'd6, 3'd0, 5'd7), 32'h0000_0000, 1'b1, 1'b0);
    add_row(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd8), 32'h0000_0006, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd9), 32'h8000_0000, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd4, 5'd3, 3'd6, 5'd10), 32'h0000_07ff, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd3, 5'd2, 3'd4, 5'd11), 32'hffff_fffa, 1'b0, 1'b0);
    // Shift amount 0x7ff masks to 31
    add_row(enc_r(7'h00, 5'd4, 5'd3, 3'd1, 5'd12), 32'h8000_0000, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd3, 5'd1, 3'd5, 5'd13), 32'h0400_0000, 1'b0, 1'b0);
    add_row(enc_r(7'h20, 5'd3, 5'd1, 3'd5, 5'd14), 32'hfc00_0000, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd3, 5'd1, 3'd2, 5'd15), 32'h0000_0001, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd3, 5'd1, 3'd3, 5'd16), 32'h0000_0000, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd2, 5'd3, 3'd2, 5'd17), 32'h0000_0000, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd2, 5'd3, 3'd3, 5'd18), 32'h0000_0001, 1'b0, 1'b0);
    add_row(enc_i(12'h0f0, 5'd2, 3'd7, 5'd19), 32'h0000_00f0, 1'b0, 1'b0);
    add_row(enc_i(12'h800, 5'd1, 3'd6, 5'd20), 32'hffff_f800, 1'b0, 1'b0);
    // Zero result from XORI leaves the flag low
    add_row(enc_i(12'hfff, 5'd2, 3'd4, 5'd21), 32'h0000_0000, 1'b0, 1'b0);
    add_row(enc_i(12'h004, 5'd3, 3'd1, 5'd22), 32'h0000_0050, 1'b0, 1'b0);
    add_row(enc_i(12'h01c, 5'd2, 3'd5, 5'd23), 32'h0000_000f, 1'b0, 1'b0);
    add_row(enc_i(12'h41f, 5'd1, 3'd5, 5'd24), 32'hffff_ffff, 1'b0, 1'b0);
    add_row(enc_i(12'h000, 5'd2, 3'd2, 5'd25), 32'h0000_0001, 1'b0, 1'b0);
    add_row(enc_i(12'hfff, 5'd3, 3'd3, 5'd26), 32'h0000_0001, 1'b0, 1'b0);
    // Write to x0, then reads at distances one and two
    add_row(enc_i(12'h007, 5'd3, 3'd0, 5'd0), 32'h0000_000c, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd27), 32'h0000_0000, 1'b1, 1'b0);
    add_row(enc_r(7'h00, 5'd3, 5'd0, 3'd0, 5'd28), 32'h0000_0005, 1'b0, 1'b0);
    add_row(enc_i(12'h003, 5'd28, 3'd0, 5'd29), 32'h0000_0008, 1'b0, 1'b0);
    add_row(enc_r(7'h00, 5'd29, 5'd28, 3'd0, 5'd30), 32'h0000_000d, 1'b0, 1'b0);
    // Unknown encodings followed by reads of their rd
    add_row(enc_r(7'h01, 5'd3, 5'd3, 3'd0, 5'd9), 32'h0000_0000, 1'b0, 1'b1);
    add_row(enc_r(7'h00, 5'd0, 5'd9, 3'd0, 5'd1), 32'h8000_0000, 1'b0, 1'b0);
    add_row({20'h00100, 5'd8, 7'b1101111}, 32'h0000_0000, 1'b0, 1'b1);
    add_row(enc_i(12'h000, 5'd8, 3'd0, 5'd6), 32'h0000_0006, 1'b0, 1'b0);
    add_row(enc_i(12'h023, 5'd4, 3'd5, 5'd10), 32'h0000_0000, 1'b0, 1'b1);
    add_row(enc_r(7'h00, 5'd0, 5'd10, 3'd0, 5'd11), 32'h0000_07ff, 1'b0, 1'b0);
  endtask

  task automatic apply_inst(input logic [31:0] word, input logic from_table, input row_t row);
    exu_pkg::commit_t exp;
    pending_t         p;
    @(posedge clock);
    #1;
    inst_valid = 1'b1;
    inst       = word;
    exp        = model_commit(word);
    model_write(exp);
    if (from_table) begin
      if (exp.result !== row.result || exp.zero !== row.zero || exp.illegal !== row.illegal) begin
        other_errors++;
        $display("Table row for instruction %h disagrees with the reference model", word);
      end
      exp.result  = row.result;
      exp.zero    = row.zero;
      exp.illegal = row.illegal;
    end
    // Accepted on the next edge, committed one edge later
    p.due = cycle_count + 32'd2;
    p.exp = exp;
    pend.push_back(p);
  endtask

  always @(negedge clock) begin
    if (checking) begin
      if (pend.size() > 0 && pend[0].due == cycle_count) begin
        check_value("commit.valid", 32'(commit.valid), 32'(pend[0].exp.valid));
        check_value("commit.illegal", 32'(commit.illegal), 32'(pend[0].exp.illegal));
        check_value("commit.rd", 32'(commit.rd), 32'(pend[0].exp.rd));
        check_value("commit.result", commit.result, pend[0].exp.result);
        check_value("commit.zero", 32'(commit.zero), 32'(pend[0].exp.zero));
        void'(pend.pop_front());
      end else begin
        check_value("commit.valid", 32'(commit.valid), 32'd0);
      end
    end
  end

  initial begin
    row_t empty_row;
    int   wait_cycles;
    rst          = 1'b1;
    inst_valid   = 1'b0;
    inst         = 32'd0;
    checking     = 1'b0;
    cycle_count  = 32'd0;
    checks       = 0;
    value_errors = 0;
    other_errors = 0;
    empty_row    = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end
    void'($urandom(SEED));
    build_table();

    repeat (2) @(posedge clock);
    #1;
    rst      = 1'b0;
    checking = 1'b1;

    foreach (rows[i]) begin
      apply_inst(rows[i].inst, 1'b1, rows[i]);
    end
    for (int n = 0; n < NUM_RANDOM; n++) begin
      apply_inst(rand_legal_inst(), 1'b0, empty_row);
    end
    @(posedge clock);
    #1;
    inst_valid = 1'b0;
    inst       = 32'd0;

    wait_cycles = 0;
    while (pend.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
      @(posedge clock);
      wait_cycles++;
    end
    if (pend.size() != 0) begin
      other_errors++;
      $display("Timeout: %0d expected commits never appeared on the commit output",
               pend.size());
    end
    // Let the last idle check at this falling edge finish first
    @(negedge clock);
    #1;

    $display("Checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
